//--- hdl/io_params.svh
/* pad count and register map of the pad control block.
   the pad count must stay between 17 and 24, since DIR, FN and OUT use byte lanes 0 to 2 only */

`ifndef IO_PARAMS_SVH
`define IO_PARAMS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// pad count
`define IO_NUM_PADS 22

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// address map, byte offsets within the decoded window
`define IO_ADR_BITS 16              // low address bits that are decoded
`define IO_ADR_DIR  16'h0000        // pad direction, 1 = output
`define IO_ADR_FN   16'h0004        // pad function, 1 = special function
`define IO_ADR_OUT  16'h0008        // gpio output data
`define IO_ADR_IN   16'h000C        // gpio input data, read only

`endif

//--- hdl/io_pkg.sv
/* bus bundles, register access and enums shared by the pad control blocks.
   the Wishbone bundles carry classic single cycles only, with no stall and no err */

`include "io_params.svh"

package io_pkg;

    typedef logic [`IO_NUM_PADS-1:0] pad_vec_t;    // one bit per pad

    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [3:0]  sel;
        logic [31:0] adr;
        logic [31:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_t;

    typedef enum logic [2:0] {
        REG_DIR,
        REG_FN,
        REG_OUT,
        REG_IN,
        REG_NONE                                    // unmapped, or no access this cycle
    } reg_sel_e;

    typedef struct packed {
        logic        wr;                            // write pulse
        reg_sel_e    sel;
        logic [3:0]  be;
        logic [31:0] wdata;
    } reg_acc_t;

    typedef enum logic {
        ST_IDLE,
        ST_ACK
    } ctrl_state_e;

    // byte lane merge of a write into a pad register
    function automatic pad_vec_t lane_merge(pad_vec_t cur, logic [31:0] wdata, logic [3:0] be);
        pad_vec_t res;
        res = cur;
        for (int b = 0; b < `IO_NUM_PADS; b++) begin
            if (be[b/8]) res[b] = wdata[b];
        end
        return res;
    endfunction

endpackage

//--- hdl/wb_io_ctrl.sv
/* Wishbone slave control for the pad registers, one access in flight at a time.
   ack follows an accepted stb by exactly one cycle; stb held during ack is ignored */

`timescale 1ns/10ps
`include "io_params.svh"

module wb_io_ctrl (
    input  logic              clk,
    input  logic              rst,
    input  io_pkg::wb_req_t   wb_req_i,
    output io_pkg::wb_rsp_t   wb_rsp_o,
    output io_pkg::reg_acc_t  acc_o,
    input  logic [31:0]       cfg_rdata_i,
    input  logic [31:0]       gpio_rdata_i
);

    io_pkg::ctrl_state_e     state_q;
    io_pkg::ctrl_state_e     state_d;
    io_pkg::reg_sel_e        dec_sel;
    logic [`IO_ADR_BITS-1:0] adr_lo;
    logic                    accept;
    logic [31:0]             rd_mux;
    logic                    ack_q;
    logic [31:0]             dat_q;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // address decode
    assign adr_lo = wb_req_i.adr[`IO_ADR_BITS-1:0];

    always_comb begin
        case (adr_lo)
            `IO_ADR_DIR: dec_sel = io_pkg::REG_DIR;
            `IO_ADR_FN:  dec_sel = io_pkg::REG_FN;
            `IO_ADR_OUT: dec_sel = io_pkg::REG_OUT;
            `IO_ADR_IN:  dec_sel = io_pkg::REG_IN;
            default:     dec_sel = io_pkg::REG_NONE;     // still acked, reads zero
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // FSM and access pulse
    assign accept = (state_q == io_pkg::ST_IDLE) && wb_req_i.cyc && wb_req_i.stb;

    always_comb begin
        case (state_q)
            io_pkg::ST_IDLE: state_d = accept ? io_pkg::ST_ACK : io_pkg::ST_IDLE;
            io_pkg::ST_ACK:  state_d = io_pkg::ST_IDLE;   // master drops stb after ack
            default:         state_d = io_pkg::ST_IDLE;
        endcase
    end

    always_comb begin
        acc_o.wr    = accept && wb_req_i.we;
        acc_o.sel   = accept ? dec_sel : io_pkg::REG_NONE;   // idle cycles target nothing
        acc_o.be    = wb_req_i.sel;
        acc_o.wdata = wb_req_i.dat;
    end

    // read data from the datapath that owns the register
    always_comb begin
        case (acc_o.sel)
            io_pkg::REG_DIR,
            io_pkg::REG_FN:  rd_mux = cfg_rdata_i;
            io_pkg::REG_OUT,
            io_pkg::REG_IN:  rd_mux = gpio_rdata_i;
            default:         rd_mux = 32'h0000_0000;
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // response registers
    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= io_pkg::ST_IDLE;
            ack_q   <= 1'b0;
        end else begin
            state_q <= state_d;
            ack_q   <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) dat_q <= rd_mux;   // value before a same-cycle write
    end

    assign wb_rsp_o.ack = ack_q;
    assign wb_rsp_o.dat = dat_q;

    // one ack per access, never back to back
    a_ack_single: assert property (@(posedge clk) disable iff (rst) ack_q |=> !ack_q)
        else $error("wb_io_ctrl: ack high for two cycles");

endmodule

//--- hdl/io_cfg_regs.sv
/* pad direction and function registers with byte lane writes.
   only lanes 0 to 2 carry pad bits; read data is zero above the pad count */

`timescale 1ns/10ps
`include "io_params.svh"

module io_cfg_regs (
    input  logic              clk,
    input  logic              rst,
    input  io_pkg::reg_acc_t  acc_i,
    output logic [31:0]       rdata_o,
    output io_pkg::pad_vec_t  dir_o,
    output io_pkg::pad_vec_t  fn_o
);

    localparam int unsigned PAD_ZEXT = 32 - `IO_NUM_PADS;   // zero fill of read data

    io_pkg::pad_vec_t dir_q;
    io_pkg::pad_vec_t fn_q;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // register writes
    always_ff @(posedge clk) begin
        if (rst) begin
            dir_q <= '0;
            fn_q  <= '0;
        end else if (acc_i.wr) begin
            case (acc_i.sel)
                io_pkg::REG_DIR: dir_q <= io_pkg::lane_merge(dir_q, acc_i.wdata, acc_i.be);
                io_pkg::REG_FN:  fn_q  <= io_pkg::lane_merge(fn_q, acc_i.wdata, acc_i.be);
                default: ;
            endcase
        end
    end

    // read path, sampled by the controller in the access cycle
    always_comb begin
        case (acc_i.sel)
            io_pkg::REG_DIR: rdata_o = {{PAD_ZEXT{1'b0}}, dir_q};
            io_pkg::REG_FN:  rdata_o = {{PAD_ZEXT{1'b0}}, fn_q};
            default:         rdata_o = 32'h0000_0000;
        endcase
    end

    assign dir_o = dir_q;
    assign fn_o  = fn_q;

    // lanes above the pad bits set nothing
    a_no_upper_bits: assert property (
        @(posedge clk) disable iff (rst)
        (acc_i.wr && (acc_i.be[2:0] == 3'b000)) |=> ($stable(dir_q) && $stable(fn_q)))
        else $error("io_cfg_regs: write without pad lanes changed a register");

endmodule

//--- hdl/io_gpio_data.sv
/* gpio output data register and the read path of the synchronized pad input.
   writes to the input register are dropped */

`timescale 1ns/10ps
`include "io_params.svh"

module io_gpio_data (
    input  logic              clk,
    input  logic              rst,
    input  io_pkg::reg_acc_t  acc_i,
    input  io_pkg::pad_vec_t  pad_in_i,
    output logic [31:0]       rdata_o,
    output io_pkg::pad_vec_t  gpio_out_o
);

    localparam int unsigned PAD_ZEXT = 32 - `IO_NUM_PADS;

    io_pkg::pad_vec_t out_q;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // output data register
    always_ff @(posedge clk) begin
        if (rst) begin
            out_q <= '0;
        end else if (acc_i.wr && (acc_i.sel == io_pkg::REG_OUT)) begin
            out_q <= io_pkg::lane_merge(out_q, acc_i.wdata, acc_i.be);
        end
    end

    // read path
    always_comb begin
        case (acc_i.sel)
            io_pkg::REG_OUT: rdata_o = {{PAD_ZEXT{1'b0}}, out_q};
            io_pkg::REG_IN:  rdata_o = {{PAD_ZEXT{1'b0}}, pad_in_i};   // already synchronized
            default:         rdata_o = 32'h0000_0000;
        endcase
    end

    assign gpio_out_o = out_q;

endmodule

//--- hdl/io_pad_mux.sv
/* per pad choice between gpio and special function, with registered pad outputs.
   pad inputs pass a two flop synchronizer and arrive two cycles late */

`timescale 1ns/10ps

module io_pad_mux (
    input  logic              clk,
    input  logic              rst,
    input  io_pkg::pad_vec_t  dir_i,
    input  io_pkg::pad_vec_t  fn_i,
    input  io_pkg::pad_vec_t  gpio_out_i,
    input  io_pkg::pad_vec_t  sf_out_i,
    input  io_pkg::pad_vec_t  sf_oe_i,
    input  io_pkg::pad_vec_t  pad_i,
    output io_pkg::pad_vec_t  pad_o,
    output io_pkg::pad_vec_t  pad_oe_o,
    output io_pkg::pad_vec_t  pad_in_o
);

    io_pkg::pad_vec_t out_sel;
    io_pkg::pad_vec_t oe_sel;
    io_pkg::pad_vec_t pad_q;
    io_pkg::pad_vec_t pad_oe_q;
    io_pkg::pad_vec_t sync1_q;
    io_pkg::pad_vec_t sync2_q;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // output side
    assign out_sel = (fn_i & sf_out_i) | (~fn_i & gpio_out_i);   // fn bit set gives sf
    assign oe_sel  = (fn_i & sf_oe_i)  | (~fn_i & dir_i);

    always_ff @(posedge clk) begin
        if (rst) begin
            pad_q    <= '0;
            pad_oe_q <= '0;   // all pads released after reset
        end else begin
            pad_q    <= out_sel;
            pad_oe_q <= oe_sel;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // input synchronizer
    always_ff @(posedge clk) begin
        sync1_q <= pad_i;
        sync2_q <= sync1_q;
    end

    assign pad_o    = pad_q;
    assign pad_oe_o = pad_oe_q;
    assign pad_in_o = sync2_q;

endmodule

//--- hdl/io_subsys_top.sv
/* pad control subsystem: Wishbone slave, config and gpio registers, pad multiplexer.
   a register write reaches the pads two cycles after the access cycle */

`timescale 1ns/10ps

module io_subsys_top (
    input  logic              clk,
    input  logic              rst,
    input  io_pkg::wb_req_t   wb_req_i,
    output io_pkg::wb_rsp_t   wb_rsp_o,
    input  io_pkg::pad_vec_t  pad_i,
    output io_pkg::pad_vec_t  pad_o,
    output io_pkg::pad_vec_t  pad_oe_o,
    input  io_pkg::pad_vec_t  sf_out_i,
    input  io_pkg::pad_vec_t  sf_oe_i,
    output io_pkg::pad_vec_t  sf_in_o
);

    io_pkg::reg_acc_t acc;
    logic [31:0]      cfg_rdata;
    logic [31:0]      gpio_rdata;
    io_pkg::pad_vec_t dir;
    io_pkg::pad_vec_t fn;
    io_pkg::pad_vec_t gpio_out;
    io_pkg::pad_vec_t pad_in;

    wb_io_ctrl u_wb_io_ctrl (
        .clk          (clk),
        .rst          (rst),
        .wb_req_i     (wb_req_i),
        .wb_rsp_o     (wb_rsp_o),
        .acc_o        (acc),
        .cfg_rdata_i  (cfg_rdata),
        .gpio_rdata_i (gpio_rdata)
    );

    io_cfg_regs u_io_cfg_regs (
        .clk     (clk),
        .rst     (rst),
        .acc_i   (acc),
        .rdata_o (cfg_rdata),
        .dir_o   (dir),
        .fn_o    (fn)
    );

    io_gpio_data u_io_gpio_data (
        .clk        (clk),
        .rst        (rst),
        .acc_i      (acc),
        .pad_in_i   (pad_in),
        .rdata_o    (gpio_rdata),
        .gpio_out_o (gpio_out)
    );

    io_pad_mux u_io_pad_mux (
        .clk        (clk),
        .rst        (rst),
        .dir_i      (dir),
        .fn_i       (fn),
        .gpio_out_i (gpio_out),
        .sf_out_i   (sf_out_i),
        .sf_oe_i    (sf_oe_i),
        .pad_i      (pad_i),
        .pad_o      (pad_o),
        .pad_oe_o   (pad_oe_o),
        .pad_in_o   (pad_in)
    );

    assign sf_in_o = pad_in;   // special function sees the synchronized input

endmodule

//--- tests/tb_clk_gen.sv
/* clock and reset source for the testbench.
   reset is synchronous to the clock and held for a fixed number of cycles */

`timescale 1ns/10ps

module tb_clk_gen #(
    parameter int PERIOD_NS  = 8,
    parameter int RST_CYCLES = 4
) (
    output logic clk_o,
    output logic rst_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    initial begin
        rst_o = 1'b1;
        repeat (RST_CYCLES) @(posedge clk_o);
        rst_o <= 1'b0;   // released on a rising edge
    end

endmodule

//--- tests/tb_io_subsys.sv
/* directed tests of the pad control subsystem over its Wishbone port.
   expected register values come from a model kept in this testbench */

`timescale 1ns/10ps
`include "io_params.svh"

module tb_io_subsys;

    localparam int          ACK_TIMEOUT = 16;   // cycles to wait for ack
    localparam int          PAD_TIMEOUT = 8;    // cycles for pads to settle
    localparam int          RST_TIMEOUT = 20;
    localparam logic [31:0] PAD_MASK    = (32'h1 << `IO_NUM_PADS) - 32'h1;

    logic             clk;
    logic             rst;
    io_pkg::wb_req_t  wb_req;
    io_pkg::wb_rsp_t  wb_rsp;
    io_pkg::pad_vec_t pad_i;
    io_pkg::pad_vec_t pad_o;
    io_pkg::pad_vec_t pad_oe;
    io_pkg::pad_vec_t sf_out;
    io_pkg::pad_vec_t sf_oe;
    io_pkg::pad_vec_t sf_in;

    integer      seed;
    int          err_count;
    int          test_count;
    logic [31:0] dir_m;   // register model
    logic [31:0] fn_m;
    logic [31:0] out_m;

    tb_clk_gen u_clk_gen (
        .clk_o (clk),
        .rst_o (rst)
    );

    io_subsys_top u_io_subsys_top (
        .clk      (clk),
        .rst      (rst),
        .wb_req_i (wb_req),
        .wb_rsp_o (wb_rsp),
        .pad_i    (pad_i),
        .pad_o    (pad_o),
        .pad_oe_o (pad_oe),
        .sf_out_i (sf_out),
        .sf_oe_i  (sf_oe),
        .sf_in_o  (sf_in)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // checks
    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %0t %s: got %h, expected %h", $time, name, got, exp);
            err_count++;
        end
    endtask

    task automatic check_pads(input string name, input io_pkg::pad_vec_t got,
                              input io_pkg::pad_vec_t exp);
        if (got !== exp) begin
            $display("[ERROR] %0t %s: got %h, expected %h", $time, name, got, exp);
            err_count++;
        end
    endtask

    task automatic check_ack(input string name, input logic seen);
        if (!seen) begin
            $display("At %0t no ack came for %s within %0d cycles", $time, name, ACK_TIMEOUT);
            err_count++;
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // helpers
    function automatic logic [31:0] rand_word();
        return $random(seed);
    endfunction

    function automatic logic [31:0] lane_mask(input logic [3:0] sel);
        return {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
    endfunction

    // only enabled bytes change, nothing lives above the pad count
    function automatic logic [31:0] merge_write(input logic [31:0] cur, input logic [31:0] wd,
                                                input logic [3:0] sel);
        return ((cur & ~lane_mask(sel)) | (wd & lane_mask(sel))) & PAD_MASK;
    endfunction

    // each pad takes the special function where its fn bit is set
    function automatic io_pkg::pad_vec_t select_pads(input io_pkg::pad_vec_t fn,
                                                     input io_pkg::pad_vec_t sf,
                                                     input io_pkg::pad_vec_t gpio);
        io_pkg::pad_vec_t res;
        for (int p = 0; p < `IO_NUM_PADS; p++) begin
            res[p] = fn[p] ? sf[p] : gpio[p];
        end
        return res;
    endfunction

    task automatic wb_access(input logic we, input logic [`IO_ADR_BITS-1:0] adr,
                             input logic [3:0] sel, input logic [31:0] wdat,
                             output logic [31:0] rdat);
        logic seen;
        seen = 1'b0;
        rdat = 32'h0;
        @(posedge clk);
        wb_req.cyc <= 1'b1;
        wb_req.stb <= 1'b1;
        wb_req.we  <= we;
        wb_req.sel <= sel;
        wb_req.adr <= {{(32-`IO_ADR_BITS){1'b0}}, adr};
        wb_req.dat <= wdat;
        for (int i = 0; i < ACK_TIMEOUT && !seen; i++) begin
            @(negedge clk);
            if (wb_rsp.ack) begin
                seen = 1'b1;
                rdat = wb_rsp.dat;
            end
        end
        @(posedge clk);
        wb_req.cyc <= 1'b0;   // stb low for a cycle before the next access
        wb_req.stb <= 1'b0;
        wb_req.we  <= 1'b0;
        check_ack($sformatf("access to %h", adr), seen);
    endtask

    task automatic wb_write(input logic [`IO_ADR_BITS-1:0] adr, input logic [3:0] sel,
                            input logic [31:0] wdat);
        logic [31:0] unused;
        wb_access(1'b1, adr, sel, wdat, unused);
        case (adr)
            `IO_ADR_DIR: dir_m = merge_write(dir_m, wdat, sel);
            `IO_ADR_FN:  fn_m  = merge_write(fn_m, wdat, sel);
            `IO_ADR_OUT: out_m = merge_write(out_m, wdat, sel);
            default: ;   // IN and unmapped hold nothing
        endcase
    endtask

    task automatic wb_read(input logic [`IO_ADR_BITS-1:0] adr, output logic [31:0] rdat);
        wb_access(1'b0, adr, 4'hF, 32'h0, rdat);
    endtask

    task automatic read_check(input string name, input logic [`IO_ADR_BITS-1:0] adr,
                              input logic [31:0] exp);
        logic [31:0] rd;
        wb_read(adr, rd);
        check_word(name, rd, exp);
    endtask

    task automatic check_regs();
        read_check("DIR", `IO_ADR_DIR, dir_m);
        read_check("FN", `IO_ADR_FN, fn_m);
        read_check("OUT", `IO_ADR_OUT, out_m);
    endtask

    task automatic wait_pads(input io_pkg::pad_vec_t exp_o, input io_pkg::pad_vec_t exp_oe);
        logic hit;
        hit = 1'b0;
        for (int i = 0; i < PAD_TIMEOUT && !hit; i++) begin
            @(negedge clk);
            hit = (pad_o === exp_o) && (pad_oe === exp_oe);
        end
        check_pads("pad_o", pad_o, exp_o);
        check_pads("pad_oe_o", pad_oe, exp_oe);
    endtask

    task automatic end_test(input string name, input int errs_before);
        test_count++;
        $display("test %-10s : %0d errors", name, err_count - errs_before);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // tests
    task automatic test_reset();
        int e0;
        e0 = err_count;
        @(negedge clk);
        check_pads("pad_o", pad_o, '0);
        check_pads("pad_oe_o", pad_oe, '0);
        check_regs();
        end_test("reset", e0);
    endtask

    task automatic test_readback();
        int e0;
        e0 = err_count;
        for (int i = 0; i < 4; i++) begin
            wb_write(`IO_ADR_DIR, 4'hF, rand_word());
            wb_write(`IO_ADR_FN, 4'hF, rand_word());
            wb_write(`IO_ADR_OUT, 4'hF, rand_word());
            check_regs();
        end
        end_test("readback", e0);
    endtask

    task automatic test_byte_lanes();
        int e0;
        e0 = err_count;
        for (int s = 1; s < 16; s++) begin
            wb_write(`IO_ADR_OUT, s[3:0], rand_word());
            read_check("OUT", `IO_ADR_OUT, out_m);
        end
        wb_write(`IO_ADR_DIR, 4'b1000, 32'hFFFF_FFFF);   // lane 3 holds no pad bits
        read_check("DIR", `IO_ADR_DIR, dir_m);
        end_test("byte_lanes", e0);
    endtask

    task automatic test_unmapped();
        int          e0;
        logic [31:0] in_before;
        e0 = err_count;
        wb_write(16'h0010, 4'hF, rand_word());
        read_check("unmapped 0x10", 16'h0010, 32'h0);
        read_check("unmapped 0x20", 16'h0020, 32'h0);
        check_regs();
        wb_read(`IO_ADR_IN, in_before);
        wb_write(`IO_ADR_IN, 4'hF, ~in_before);
        read_check("IN", `IO_ADR_IN, in_before);
        check_regs();   // the IN write lands in no other register
        end_test("unmapped", e0);
    endtask

    task automatic test_pad_mux();
        int               e0;
        io_pkg::pad_vec_t fn_v;
        io_pkg::pad_vec_t out_v;
        io_pkg::pad_vec_t dir_v;
        e0 = err_count;
        @(posedge clk);
        sf_out <= io_pkg::pad_vec_t'(rand_word());
        sf_oe  <= io_pkg::pad_vec_t'(rand_word());
        wb_write(`IO_ADR_FN, 4'hF, 32'h0);
        wb_write(`IO_ADR_DIR, 4'hF, rand_word());
        wb_write(`IO_ADR_OUT, 4'hF, rand_word());
        out_v = out_m[`IO_NUM_PADS-1:0];
        dir_v = dir_m[`IO_NUM_PADS-1:0];
        wait_pads(out_v, dir_v);
        wb_write(`IO_ADR_FN, 4'hF, rand_word());
        fn_v = fn_m[`IO_NUM_PADS-1:0];
        wait_pads(select_pads(fn_v, sf_out, out_v), select_pads(fn_v, sf_oe, dir_v));
        end_test("pad_mux", e0);
    endtask

    task automatic test_input();
        int               e0;
        io_pkg::pad_vec_t v;
        logic [31:0]      w;
        e0 = err_count;
        for (int i = 0; i < 4; i++) begin
            w = rand_word();
            v = w[`IO_NUM_PADS-1:0];
            @(posedge clk);
            pad_i <= v;
            repeat (3) @(posedge clk);   // two sync flops plus margin
            read_check("IN", `IO_ADR_IN, {{(32-`IO_NUM_PADS){1'b0}}, v});
            @(negedge clk);
            check_pads("sf_in_o", sf_in, v);
        end
        end_test("input", e0);
    endtask

    task automatic wait_reset();
        logic done;
        done = 1'b0;
        for (int i = 0; i < RST_TIMEOUT && !done; i++) begin
            @(negedge clk);
            done = !rst;
        end
        if (!done) begin
            $display("Reset was not released within %0d cycles", RST_TIMEOUT);
            err_count++;
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // main sequence
    initial begin
        wb_req     = '0;
        pad_i      = '0;
        sf_out     = '0;
        sf_oe      = '0;
        seed       = 32'h4cd6_54d4;
        err_count  = 0;
        test_count = 0;
        dir_m      = 32'h0;
        fn_m       = 32'h0;
        out_m      = 32'h0;
        wait_reset();
        test_reset();
        test_readback();
        test_byte_lanes();
        test_unmapped();
        test_pad_mux();
        test_input();
        $display("%0d tests run, %0d errors", test_count, err_count);
        if (err_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

//--- sim.f
+incdir+hdl
hdl/io_pkg.sv
hdl/wb_io_ctrl.sv
hdl/io_cfg_regs.sv
hdl/io_gpio_data.sv
hdl/io_pad_mux.sv
hdl/io_subsys_top.sv
tests/tb_clk_gen.sv
tests/tb_io_subsys.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       := tb_io_subsys
FILELIST  := sim.f
OBJ_DIR   := obj_dir
LOG       := sim.log

BIN  := $(OBJ_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FILELIST))
HDRS := hdl/io_params.svh

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -q "^Finished with no errors$$" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
